/* logic/serial_alu_params.svh */
`ifndef SERIAL_ALU_PARAMS_SVH
`define SERIAL_ALU_PARAMS_SVH

// operand and result word
`define SA_WIDTH 16

// counts the SA_WIDTH bit steps
`define SA_CNT_WIDTH 4

// opcode field
`define SA_OP_WIDTH 3

`endif

/* logic/serial_alu_pkg.sv */
`default_nettype none

`include "serial_alu_params.svh"

package serial_alu_pkg;

    typedef logic [`SA_WIDTH-1:0] word_t;
    typedef logic [`SA_WIDTH:0] result_t;      // carry in the top bit
    typedef logic [`SA_CNT_WIDTH-1:0] bit_cnt_t;

    typedef enum logic [`SA_OP_WIDTH-1:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_XOR  = 3'd2,
        OP_AND  = 3'd3,
        OP_NOT  = 3'd4,     // not a, b ignored
        OP_OR   = 3'd5,
        OP_NOR  = 3'd6,
        OP_NAND = 3'd7
    } op_t;

endpackage

`default_nettype wire

/* logic/alu_sequencer.sv */
`default_nettype none

`include "serial_alu_params.svh"

module alu_sequencer (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    output logic in_ready,
    output logic out_valid,
    input  logic out_ready,
    output logic load,
    output logic step
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_DONE
    } state_t;

    // last bit of the word
    localparam serial_alu_pkg::bit_cnt_t CNT_LAST = {`SA_CNT_WIDTH{1'b1}};

    state_t state;
    serial_alu_pkg::bit_cnt_t cnt;

    assign in_ready  = (state == S_IDLE);
    assign out_valid = (state == S_DONE);
    assign load      = in_valid && in_ready;   // accept edge
    assign step      = (state == S_RUN);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (load) begin
                        state <= S_RUN;
                        cnt   <= '0;
                    end
                end

                S_RUN: begin
                    cnt <= cnt + 1'b1;
                    // bit 15 done on this edge
                    if (cnt == CNT_LAST) begin
                        state <= S_DONE;
                    end
                end

                S_DONE: begin
                    if (out_ready) begin
                        state <= S_IDLE;   // result taken
                    end
                end

                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/operand_shifter.sv */
`default_nettype none

`include "serial_alu_params.svh"

module operand_shifter (
    input  logic                  clk,
    input  logic                  load,
    input  logic                  step,
    input  serial_alu_pkg::word_t in_a,
    input  serial_alu_pkg::word_t in_b,
    output logic                  a_bit,
    output logic                  b_bit
);

    serial_alu_pkg::word_t a_reg;
    serial_alu_pkg::word_t b_reg;

    // current bit sits in the lsb
    assign a_bit = a_reg[0];
    assign b_bit = b_reg[0];

    always_ff @(posedge clk) begin
        if (load) begin
            a_reg <= in_a;
            b_reg <= in_b;
        end else if (step) begin
            a_reg <= {1'b0, a_reg[`SA_WIDTH-1:1]};
            b_reg <= {1'b0, b_reg[`SA_WIDTH-1:1]};
        end
    end

endmodule

`default_nettype wire

/* logic/bit_alu.sv */
`default_nettype none

module bit_alu (
    input  logic                clk,
    input  logic                rst,
    input  logic                load,
    input  logic                step,
    input  serial_alu_pkg::op_t in_op,
    input  logic                a_bit,
    input  logic                b_bit,
    output logic                res_bit,
    output logic                carry
);

    serial_alu_pkg::op_t op_reg;
    logic carry_reg;
    logic is_arith;
    logic b_eff;
    logic sum;

    assign is_arith = (op_reg == serial_alu_pkg::OP_ADD) ||
                      (op_reg == serial_alu_pkg::OP_SUB);

    // subtract adds the inverted b
    assign b_eff = b_bit ^ (op_reg == serial_alu_pkg::OP_SUB);
    assign sum   = a_bit ^ b_eff ^ carry_reg;

    // carry out of the current bit, zero for logic ops
    assign carry = is_arith &
                   ((a_bit & b_eff) | (carry_reg & (a_bit ^ b_eff)));

    always_comb begin
        case (op_reg)
            serial_alu_pkg::OP_XOR:  res_bit = a_bit ^ b_bit;
            serial_alu_pkg::OP_AND:  res_bit = a_bit & b_bit;
            serial_alu_pkg::OP_NOT:  res_bit = ~a_bit;
            serial_alu_pkg::OP_OR:   res_bit = a_bit | b_bit;
            serial_alu_pkg::OP_NOR:  res_bit = ~(a_bit | b_bit);
            serial_alu_pkg::OP_NAND: res_bit = ~(a_bit & b_bit);
            default:                 res_bit = sum;   // add, sub
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op_reg    <= serial_alu_pkg::OP_ADD;
            carry_reg <= 1'b0;
        end else if (load) begin
            op_reg    <= in_op;
            // two's complement needs the extra one
            carry_reg <= (in_op == serial_alu_pkg::OP_SUB);
        end else if (step) begin
            carry_reg <= carry;
        end
    end

endmodule

`default_nettype wire

/* logic/result_shifter.sv */
`default_nettype none

`include "serial_alu_params.svh"

module result_shifter (
    input  logic                    clk,
    input  logic                    load,
    input  logic                    step,
    input  logic                    res_bit,
    input  logic                    carry,
    output serial_alu_pkg::result_t out_result
);

    serial_alu_pkg::result_t res_reg;

    assign out_result = res_reg;

    always_ff @(posedge clk) begin
        if (load) begin
            res_reg <= '0;   // fresh word per operation
        end else if (step) begin
            // last carry copied wins
            res_reg[`SA_WIDTH] <= carry;

            // new bit enters at the msb, older bits move down
            res_reg[`SA_WIDTH-1:0] <= {res_bit, res_reg[`SA_WIDTH-1:1]};
        end
    end

endmodule

`default_nettype wire

/* logic/serial_alu_top.sv */
`default_nettype none

`include "serial_alu_params.svh"

module serial_alu_top (
    input  logic                clk,
    input  logic                rst,

    input  logic                in_valid,
    output logic                in_ready,
    input  logic [`SA_WIDTH-1:0] in_a,
    input  logic [`SA_WIDTH-1:0] in_b,
    input  serial_alu_pkg::op_t in_op,

    output logic                out_valid,
    input  logic                out_ready,
    output logic [`SA_WIDTH:0]  out_result
);

    logic load;
    logic step;
    logic a_bit;
    logic b_bit;
    logic res_bit;
    logic carry;

    // handshake and bit count
    alu_sequencer u_seq (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .load      (load),
        .step      (step)
    );

    operand_shifter u_opnd (
        .clk   (clk),
        .load  (load),
        .step  (step),
        .in_a  (in_a),
        .in_b  (in_b),
        .a_bit (a_bit),
        .b_bit (b_bit)
    );

    // one bit per clock
    bit_alu u_alu (
        .clk     (clk),
        .rst     (rst),
        .load    (load),
        .step    (step),
        .in_op   (in_op),
        .a_bit   (a_bit),
        .b_bit   (b_bit),
        .res_bit (res_bit),
        .carry   (carry)
    );

    result_shifter u_res (
        .clk        (clk),
        .load       (load),
        .step       (step),
        .res_bit    (res_bit),
        .carry      (carry),
        .out_result (out_result)
    );

endmodule

`default_nettype wire

/* testbench/serial_alu_asserts.sv */
`default_nettype none

`include "serial_alu_params.svh"

module serial_alu_asserts (
    input logic               clk,
    input logic               rst,
    input logic               in_ready,
    input logic               out_valid,
    input logic               out_ready,
    input logic               load,
    input logic [`SA_WIDTH:0] out_result
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;   // failed assertions so far

    // one operation in flight at a time
    no_overlap: assert property (@(posedge clk) disable iff (rst)
        $rose(in_ready) |-> $past(out_valid && out_ready))
    else begin
        $error("in_ready rose without an output handshake");
        fail_cnt++;
    end

    hold_result: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_result))
    else begin
        $error("output changed while out_ready low");
        fail_cnt++;
    end

    // rises after the 16th edge past the accept edge
    fixed_latency: assert property (@(posedge clk) disable iff (rst)
        load |-> ##17 $rose(out_valid))
    else begin
        $error("out_valid did not rise 16 cycles after load");
        fail_cnt++;
    end

endmodule

bind serial_alu_top serial_alu_asserts u_asserts (
    .clk        (clk),
    .rst        (rst),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .load       (load),
    .out_result (out_result)
);

`default_nettype wire

/* testbench/serial_alu_tb.sv */
`default_nettype none

`include "serial_alu_params.svh"

module serial_alu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_OPS        = 300;
    localparam int LATENCY        = 16;   // edges from accept to out_valid
    localparam int TIMEOUT_CYCLES = NUM_OPS * 40;
    localparam int unsigned SEED  = 82769;

    logic                 clk;
    logic                 rst;
    logic                 in_valid;
    logic                 in_ready;
    logic [`SA_WIDTH-1:0] in_a;
    logic [`SA_WIDTH-1:0] in_b;
    serial_alu_pkg::op_t  in_op;
    logic                 out_valid;
    logic                 out_ready;
    logic [`SA_WIDTH:0]   out_result;

    int errors;
    int n_done;

    serial_alu_top dut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_a       (in_a),
        .in_b       (in_b),
        .in_op      (in_op),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reference model, 17-bit result with carry on top
    function automatic logic [`SA_WIDTH:0] expected_result(
        input logic [`SA_WIDTH-1:0] a,
        input logic [`SA_WIDTH-1:0] b,
        input serial_alu_pkg::op_t  op
    );
        logic [`SA_WIDTH:0] r;
        case (op)
            serial_alu_pkg::OP_ADD:  r = {1'b0, a} + {1'b0, b};
            serial_alu_pkg::OP_SUB:  r = {1'b0, a} + {1'b0, ~b} + 1'b1;   // top bit set = no borrow
            serial_alu_pkg::OP_XOR:  r = {1'b0, a ^ b};
            serial_alu_pkg::OP_AND:  r = {1'b0, a & b};
            serial_alu_pkg::OP_NOT:  r = {1'b0, ~a};
            serial_alu_pkg::OP_OR:   r = {1'b0, a | b};
            serial_alu_pkg::OP_NOR:  r = {1'b0, ~(a | b)};
            serial_alu_pkg::OP_NAND: r = {1'b0, ~(a & b)};
            default:                 r = 'x;
        endcase
        return r;
    endfunction

    // corner values mixed into the random words
    function automatic logic [`SA_WIDTH-1:0] random_word();
        logic [`SA_WIDTH-1:0] w;
        case ($urandom_range(7))
            0:       w = '0;
            1:       w = '1;
            2:       w = {1'b1, {(`SA_WIDTH-1){1'b0}}};
            default: w = $urandom();
        endcase
        return w;
    endfunction

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: %0d cycles passed with %0d of %0d results received",
                 TIMEOUT_CYCLES, n_done, NUM_OPS);
        $display("Done: errors found");
        $finish;
    end

    initial begin : stimulus
        logic [`SA_WIDTH:0]  exp_q[$];
        serial_alu_pkg::op_t op_q[$];
        logic [`SA_WIDTH:0]  exp_val;
        serial_alu_pkg::op_t exp_op;
        logic [`SA_WIDTH:0]  held_result;
        logic fire_in;
        logic fire_out;
        logic holding;
        logic after_out;
        logic valid_seen;
        int   n_sent;
        int   edge_cnt;
        int   accept_edge;
        int   assert_fails;

        errors      = 0;
        n_done      = 0;
        n_sent      = 0;
        edge_cnt    = 0;
        accept_edge = 0;
        holding     = 1'b0;
        after_out   = 1'b0;
        valid_seen  = 1'b0;
        held_result = '0;
        void'($urandom(SEED));

        rst       = 1'b1;
        in_valid  = 1'b0;
        in_a      = '0;
        in_b      = '0;
        in_op     = serial_alu_pkg::OP_ADD;
        out_ready = 1'b0;

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (!in_ready || out_valid) begin
            errors++;
            $display("** Error @ %0t: after reset in_ready=%b out_valid=%b",
                     $time, in_ready, out_valid);
        end

        while (n_done < NUM_OPS) begin
            // sampled mid-cycle, the next edge acts on these
            fire_in  = in_valid && in_ready;
            fire_out = out_valid && out_ready;

            if (after_out && !in_ready) begin
                errors++;
                $display("** Error @ %0t: in_ready low one cycle after output handshake",
                         $time);
            end
            if (holding && !out_valid) begin
                errors++;
                $display("** Error @ %0t: out_valid dropped while out_ready low", $time);
            end
            if (holding && out_result !== held_result) begin
                errors++;
                $display("** Error @ %0t: out_result changed under back-pressure %h -> %h",
                         $time, held_result, out_result);
            end
            if (out_valid && in_ready) begin
                errors++;
                $display("** Error @ %0t: in_ready high while out_valid high", $time);
            end
            if (out_valid && !valid_seen) begin
                valid_seen = 1'b1;
                if (edge_cnt - accept_edge != LATENCY) begin
                    errors++;
                    $display("** Error @ %0t: out_valid rose %0d edges after accept, not %0d",
                             $time, edge_cnt - accept_edge, LATENCY);
                end
            end
            if (fire_out) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("** Error @ %0t: result handed out with no operation in flight",
                             $time);
                end else begin
                    exp_val = exp_q.pop_front();
                    exp_op  = op_q.pop_front();
                    if (out_result !== exp_val) begin
                        errors++;
                        $display("** Error @ %0t: %s result %h, expected %h",
                                 $time, exp_op.name(), out_result, exp_val);
                    end
                end
                n_done++;
                valid_seen = 1'b0;
            end
            if (fire_in) begin
                exp_q.push_back(expected_result(in_a, in_b, in_op));
                op_q.push_back(in_op);
                accept_edge = edge_cnt + 1;
                n_sent++;
            end
            holding     = out_valid && !out_ready;
            held_result = out_result;
            after_out   = fire_out;

            @(posedge clk);
            edge_cnt++;
            // a presented operation stays until taken
            if (fire_in || !in_valid) begin
                if (n_sent < NUM_OPS && $urandom_range(3) != 0) begin
                    in_valid <= 1'b1;
                    in_a     <= random_word();
                    in_b     <= random_word();
                    in_op    <= serial_alu_pkg::op_t'($urandom_range(7));
                end else begin
                    in_valid <= 1'b0;
                end
            end
            out_ready <= ($urandom_range(2) != 0);
            @(negedge clk);
        end

        assert_fails = dut.u_asserts.fail_cnt;
        $display("errors: %0d in checks, %0d in assertions, %0d results compared",
                 errors, assert_fails, n_done);
        if (errors == 0 && assert_fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+logic
logic/serial_alu_pkg.sv
logic/alu_sequencer.sv
logic/operand_shifter.sv
logic/bit_alu.sv
logic/result_shifter.sv
logic/serial_alu_top.sv
testbench/serial_alu_asserts.sv
testbench/serial_alu_tb.sv

/* Bender.yml */
package:
  name: serial_alu

sources:
  - include_dirs:
      - logic
    files:
      - logic/serial_alu_pkg.sv
      - logic/alu_sequencer.sv
      - logic/operand_shifter.sv
      - logic/bit_alu.sv
      - logic/result_shifter.sv
      - logic/serial_alu_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/serial_alu_asserts.sv
      - testbench/serial_alu_tb.sv
